/* logic/cache_pkg.sv */
package cache_pkg;

	// pipeline side widths
	localparam int ADDR_W = 16;         // byte address
	localparam int DATA_W = 16;         // one cache / memory word

	// address split: tag | set index | word | byte
	localparam int TAG_W      = 5;      // addr[15:11]
	localparam int INDEX_W    = 7;      // addr[10:4]
	localparam int WORD_SEL_W = 3;      // addr[3:1], addr[0] ignored

	// geometry
	localparam int NUM_SETS        = 128;
	localparam int WORDS_PER_BLOCK = 8;

	// block fill sequencer states
	typedef enum logic [1:0] {
		FILL_IDLE,                  // no fill, write-through may use the channel
		FILL_ISSUE,                 // sending block reads as credits allow
		FILL_DRAIN,                 // all reads sent, waiting on responses
		FILL_LAST                   // only the final response is still due
	} fill_state_e;

endpackage

/* logic/mem_pkg.sv */
package mem_pkg;

	// backing store is word addressed
	localparam int MEM_WORDS   = 32768;
	localparam int MEM_WADDR_W = $clog2(MEM_WORDS);   // 15 bits, byte addr[15:1]

	// power-up pattern, word at byte addr a is {a[15:1],0} ^ this
	localparam logic [15:0] MEM_INIT_XOR = 16'hC3A5;

	// request channel opcode
	typedef enum logic {
		MEM_OP_READ  = 1'b0,        // returns one mrsp_valid pulse
		MEM_OP_WRITE = 1'b1         // no response, array updated at completion
	} mem_op_e;

endpackage

/* logic/cache_meta_array.sv */
`timescale 1ns/1ns

module cache_meta_array (
	input  logic                          clk,
	input  logic                          arst_n,
	input  logic [cache_pkg::INDEX_W-1:0] index,     // set under lookup or fill
	input  logic                          write,     // install tag at end of fill
	input  logic [cache_pkg::TAG_W-1:0]   tag_in,
	output logic [cache_pkg::TAG_W-1:0]   tag_out,
	output logic                          valid_out
);

	logic [cache_pkg::TAG_W-1:0]    tag_mem [cache_pkg::NUM_SETS];
	logic [cache_pkg::NUM_SETS-1:0] valid_q;        // one valid bit per set
	logic [cache_pkg::NUM_SETS-1:0] set_sel;        // one-hot set decode

	assign set_sel = cache_pkg::NUM_SETS'(1) << index;

	// valid bits are the only state cleared on reset
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			valid_q <= '0;
		end else if (write) begin
			valid_q <= valid_q | set_sel;       // valid rises with the tag
		end
	end

	always_ff @(posedge clk) begin
		if (write) begin
			tag_mem[index] <= tag_in;
		end
	end

	// lookup is combinational so a hit resolves in the request cycle
	assign tag_out   = tag_mem[index];
	assign valid_out = |(valid_q & set_sel);

endmodule

/* logic/cache_data_array.sv */
`timescale 1ns/1ns

module cache_data_array (
	input  logic                             clk,
	input  logic                             arst_n,
	input  logic [cache_pkg::INDEX_W-1:0]    index,     // set
	input  logic [cache_pkg::WORD_SEL_W-1:0] word_sel,  // word within the block
	input  logic                             write,
	input  logic [cache_pkg::DATA_W-1:0]     data_in,
	output logic [cache_pkg::DATA_W-1:0]     data_out
);

	localparam int LINE_W = cache_pkg::INDEX_W + cache_pkg::WORD_SEL_W;
	localparam int DEPTH  = cache_pkg::NUM_SETS * cache_pkg::WORDS_PER_BLOCK;

	logic [cache_pkg::DATA_W-1:0] data_mem [DEPTH];  // flat set-major word store
	logic [LINE_W-1:0]            word_addr;         // {set, word}
	logic                         write_ok;

	assign word_addr = {index, word_sel};

	// nothing lands in the store while reset is held
	assign write_ok = write && arst_n;

	always_ff @(posedge clk) begin
		if (write_ok) begin
			data_mem[word_addr] <= data_in;     // fill word or write-through data
		end
	end

	// contents undefined until the set's block has been filled,
	// the tag valid bit keeps those words from ever being returned
	assign data_out = data_mem[word_addr];

endmodule

/* logic/cache_mem_ctrl.sv */
`timescale 1ns/1ns

module cache_mem_ctrl #(
	parameter int MEM_CREDITS = 4
) (
	input  logic                             clk,
	input  logic                             arst_n,
	input  logic                             miss,        // start a block fill
	input  logic [cache_pkg::ADDR_W-1:0]     miss_addr,
	input  logic                             wt_req,      // write hit wants the channel
	input  logic [cache_pkg::ADDR_W-1:0]     wt_addr,
	input  logic [cache_pkg::DATA_W-1:0]     wt_data,
	input  logic                             credit_ret,  // memory popped one entry
	input  logic                             mrsp_valid,
	input  logic [cache_pkg::DATA_W-1:0]     mrsp_data,
	output logic                             busy,
	output logic [cache_pkg::WORD_SEL_W-1:0] fill_word,   // word the response belongs to
	output logic                             fill_write,
	output logic                             tag_write,
	output logic                             wt_ready,
	output logic                             mreq_valid,
	output mem_pkg::mem_op_e                 mreq_op,
	output logic [cache_pkg::ADDR_W-1:0]     mreq_addr,
	output logic [cache_pkg::DATA_W-1:0]     mreq_data
);

	localparam int CRED_W = $clog2(MEM_CREDITS + 1);
	localparam int BLK_W  = cache_pkg::ADDR_W - cache_pkg::WORD_SEL_W - 1;  // tag + index
	localparam logic [cache_pkg::WORD_SEL_W-1:0] LAST_WORD =
		cache_pkg::WORD_SEL_W'(cache_pkg::WORDS_PER_BLOCK - 1);

	cache_pkg::fill_state_e           state, state_nxt;
	logic [BLK_W-1:0]                 blk_addr;      // block being filled
	logic [cache_pkg::WORD_SEL_W-1:0] iss_cnt;       // next word to request
	logic [cache_pkg::WORD_SEL_W-1:0] rsp_cnt;       // next word to come back
	logic [cache_pkg::WORD_SEL_W-1:0] rsp_cnt_nxt;
	logic [CRED_W-1:0]                credit_cnt;
	logic                             has_credit;
	logic                             fill_send;
	logic                             wt_send;

	assign has_credit = (credit_cnt != '0);
	assign busy       = (state != cache_pkg::FILL_IDLE);
	assign fill_send  = (state == cache_pkg::FILL_ISSUE) && has_credit;
	assign wt_ready   = !busy && has_credit;              // fills own the channel
	assign wt_send    = wt_req && wt_ready;

	// fill reads and write-through never overlap on the one request channel
	assign mreq_valid = fill_send || wt_send;
	assign mreq_op    = fill_send ? mem_pkg::MEM_OP_READ : mem_pkg::MEM_OP_WRITE;
	assign mreq_addr  = fill_send ? {blk_addr, iss_cnt, 1'b0} : wt_addr;
	assign mreq_data  = wt_data;                          // ignored on reads

	// responses come back in order, so rsp_cnt is the word select
	assign fill_word   = rsp_cnt;
	assign fill_write  = busy && mrsp_valid;
	assign tag_write   = (state == cache_pkg::FILL_LAST) && mrsp_valid;
	assign rsp_cnt_nxt = mrsp_valid ? rsp_cnt + 1'b1 : rsp_cnt;

	always_comb begin
		state_nxt = state;
		case (state)
			cache_pkg::FILL_IDLE: begin
				if (miss) state_nxt = cache_pkg::FILL_ISSUE;
			end
			cache_pkg::FILL_ISSUE: begin
				// with one credit the 7th response can meet the last send
				if (fill_send && iss_cnt == LAST_WORD) begin
					state_nxt = (rsp_cnt_nxt == LAST_WORD) ? cache_pkg::FILL_LAST
					                                       : cache_pkg::FILL_DRAIN;
				end
			end
			cache_pkg::FILL_DRAIN: begin
				if (rsp_cnt_nxt == LAST_WORD) state_nxt = cache_pkg::FILL_LAST;
			end
			cache_pkg::FILL_LAST: begin
				if (mrsp_valid) state_nxt = cache_pkg::FILL_IDLE;  // lookup hits next cycle
			end
			default: state_nxt = cache_pkg::FILL_IDLE;
		endcase
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state   <= cache_pkg::FILL_IDLE;
			iss_cnt <= '0;
			rsp_cnt <= '0;
		end else begin
			state   <= state_nxt;
			rsp_cnt <= rsp_cnt_nxt;                     // wraps to 0 after word 7
			if (fill_send) iss_cnt <= iss_cnt + 1'b1;  // wraps to 0 after word 7
		end
	end

	always_ff @(posedge clk) begin
		if (!busy && miss) begin
			blk_addr <= miss_addr[cache_pkg::ADDR_W-1 -: BLK_W];
		end
	end

	// a return and a send in the same cycle cancel
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			credit_cnt <= CRED_W'(MEM_CREDITS);
		end else if (credit_ret && !mreq_valid) begin
			credit_cnt <= credit_cnt + 1'b1;
		end else if (!credit_ret && mreq_valid) begin
			credit_cnt <= credit_cnt - 1'b1;
		end
	end

	a_credit_max: assert property (@(posedge clk) disable iff (!arst_n)
		credit_cnt <= CRED_W'(MEM_CREDITS));   // more returns than sends
	a_credit_min: assert property (@(posedge clk) disable iff (!arst_n)
		(credit_cnt == '0 && !credit_ret) |=> (credit_cnt == '0));  // a send would wrap it
	a_rsp_in_fill: assert property (@(posedge clk) disable iff (!arst_n)
		mrsp_valid |-> busy);                  // only fill reads get answers
	a_rsp_known: assert property (@(posedge clk) disable iff (!arst_n)
		mrsp_valid |-> !$isunknown(mrsp_data));

endmodule

/* logic/cache_unit.sv */
`timescale 1ns/1ns

module cache_unit #(
	parameter int MEM_CREDITS = 4
) (
	input  logic                         clk,
	input  logic                         arst_n,
	input  logic                         rd_en,
	input  logic                         wr_en,
	input  logic [cache_pkg::ADDR_W-1:0] addr,        // held by the pipeline while stalled
	input  logic [cache_pkg::DATA_W-1:0] wr_data,
	input  logic                         credit_ret,
	input  logic                         mrsp_valid,
	input  logic [cache_pkg::DATA_W-1:0] mrsp_data,
	output logic [cache_pkg::DATA_W-1:0] rd_data,
	output logic                         hit,
	output logic                         stall,
	output logic                         mreq_valid,
	output mem_pkg::mem_op_e             mreq_op,
	output logic [cache_pkg::ADDR_W-1:0] mreq_addr,
	output logic [cache_pkg::DATA_W-1:0] mreq_data
);

	logic [cache_pkg::TAG_W-1:0]      tag, tag_out;
	logic [cache_pkg::INDEX_W-1:0]    set_index;
	logic [cache_pkg::WORD_SEL_W-1:0] addr_word, fill_word, word_sel;
	logic [cache_pkg::DATA_W-1:0]     data_in;
	logic valid_out, lookup_hit, req, miss, busy;
	logic wt_req, wt_ready, fill_write, tag_write;
	logic accept, data_write, fill_seen;

	// tag | index | word | byte
	assign tag       = addr[cache_pkg::ADDR_W-1 -: cache_pkg::TAG_W];
	assign set_index = addr[cache_pkg::WORD_SEL_W + 1 +: cache_pkg::INDEX_W];
	assign addr_word = addr[1 +: cache_pkg::WORD_SEL_W];

	assign req        = rd_en || wr_en;
	assign lookup_hit = valid_out && (tag_out == tag);
	assign miss       = req && !lookup_hit && !busy;   // read or write, both allocate
	assign wt_req     = wr_en && lookup_hit && !busy;

	// write hit without a free credit waits here
	assign stall  = miss || busy || (wt_req && !wt_ready);
	assign accept = req && !stall;
	assign hit    = accept && !fill_seen;

	// fill owns the data port while busy
	assign word_sel   = busy ? fill_word : addr_word;
	assign data_in    = busy ? mrsp_data : wr_data;
	assign data_write = fill_write || (wr_en && accept);

	// remembers that this request needed a fill
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			fill_seen <= 1'b0;
		end else if (miss) begin
			fill_seen <= 1'b1;
		end else if (accept) begin
			fill_seen <= 1'b0;
		end
	end

	cache_meta_array u_meta (
		.clk       (clk),
		.arst_n    (arst_n),
		.index     (set_index),
		.write     (tag_write),
		.tag_in    (tag),
		.tag_out   (tag_out),
		.valid_out (valid_out)
	);

	cache_data_array u_data (
		.clk      (clk),
		.arst_n   (arst_n),
		.index    (set_index),
		.word_sel (word_sel),
		.write    (data_write),
		.data_in  (data_in),
		.data_out (rd_data)
	);

	cache_mem_ctrl #(
		.MEM_CREDITS (MEM_CREDITS)
	) u_ctrl (
		.clk        (clk),
		.arst_n     (arst_n),
		.miss       (miss),
		.miss_addr  (addr),
		.wt_req     (wt_req),
		.wt_addr    (addr),
		.wt_data    (wr_data),
		.credit_ret (credit_ret),
		.mrsp_valid (mrsp_valid),
		.mrsp_data  (mrsp_data),
		.busy       (busy),
		.fill_word  (fill_word),
		.fill_write (fill_write),
		.tag_write  (tag_write),
		.wt_ready   (wt_ready),
		.mreq_valid (mreq_valid),
		.mreq_op    (mreq_op),
		.mreq_addr  (mreq_addr),
		.mreq_data  (mreq_data)
	);

	a_one_op: assert property (@(posedge clk) disable iff (!arst_n)
		!(rd_en && wr_en));
	// held request finds its block installed once the fill ends
	a_fill_hits: assert property (@(posedge clk) disable iff (!arst_n)
		(req && $fell(busy)) |-> lookup_hit);

endmodule

/* logic/main_memory.sv */
`timescale 1ns/1ns

module main_memory #(
	parameter int MEM_CREDITS = 4,
	parameter int MEM_LATENCY = 3
) (
	input  logic                         clk,
	input  logic                         arst_n,
	input  logic                         mreq_valid,
	input  mem_pkg::mem_op_e             mreq_op,
	input  logic [cache_pkg::ADDR_W-1:0] mreq_addr,   // byte address
	input  logic [cache_pkg::DATA_W-1:0] mreq_data,
	output logic                         credit_ret,  // one pulse per pop
	output logic                         mrsp_valid,
	output logic [cache_pkg::DATA_W-1:0] mrsp_data
);

	localparam int PTR_W = (MEM_CREDITS > 1) ? $clog2(MEM_CREDITS) : 1;
	localparam int CNT_W = $clog2(MEM_CREDITS + 1);
	localparam int LAT_W = $clog2(MEM_LATENCY + 1);

	logic [cache_pkg::DATA_W-1:0]    mem [mem_pkg::MEM_WORDS];
	mem_pkg::mem_op_e                q_op   [MEM_CREDITS];   // request queue
	logic [mem_pkg::MEM_WADDR_W-1:0] q_addr [MEM_CREDITS];
	logic [cache_pkg::DATA_W-1:0]    q_data [MEM_CREDITS];
	logic [PTR_W-1:0]                wr_ptr, rd_ptr;
	logic [CNT_W-1:0]                q_count;
	mem_pkg::mem_op_e                cur_op;                  // request in service
	logic [mem_pkg::MEM_WADDR_W-1:0] cur_addr;
	logic [cache_pkg::DATA_W-1:0]    cur_data;
	logic [LAT_W-1:0]                lat_cnt;
	logic                            active, done, pop;

	function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] p);
		return (p == PTR_W'(MEM_CREDITS - 1)) ? '0 : p + 1'b1;  // depth need not be 2^n
	endfunction

	initial begin
		for (int w = 0; w < mem_pkg::MEM_WORDS; w++) begin
			mem[w] = cache_pkg::DATA_W'(w << 1) ^ mem_pkg::MEM_INIT_XOR;
		end
	end

	assign done       = active && (lat_cnt == LAT_W'(1));
	assign pop        = (q_count != '0) && (!active || done);  // next one starts as one ends
	assign credit_ret = pop;
	assign mrsp_valid = done && (cur_op == mem_pkg::MEM_OP_READ);
	assign mrsp_data  = mem[cur_addr];

	always_ff @(posedge clk) begin
		if (mreq_valid) begin
			q_op[wr_ptr]   <= mreq_op;
			q_addr[wr_ptr] <= mreq_addr[cache_pkg::ADDR_W-1:1];
			q_data[wr_ptr] <= mreq_data;
		end
		if (pop) begin
			cur_op   <= q_op[rd_ptr];
			cur_addr <= q_addr[rd_ptr];
			cur_data <= q_data[rd_ptr];
		end
		if (done && cur_op == mem_pkg::MEM_OP_WRITE) begin
			mem[cur_addr] <= cur_data;           // later reads see it, strict order
		end
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			wr_ptr  <= '0;
			rd_ptr  <= '0;
			q_count <= '0;
			active  <= 1'b0;
			lat_cnt <= '0;
		end else begin
			if (mreq_valid) wr_ptr <= ptr_inc(wr_ptr);
			if (pop) rd_ptr <= ptr_inc(rd_ptr);
			case ({mreq_valid, pop})
				2'b10:   q_count <= q_count + 1'b1;
				2'b01:   q_count <= q_count - 1'b1;
				default: q_count <= q_count;
			endcase
			if (pop) begin
				active  <= 1'b1;
				lat_cnt <= LAT_W'(MEM_LATENCY);
			end else if (done) begin
				active <= 1'b0;
			end else if (active) begin
				lat_cnt <= lat_cnt - 1'b1;
			end
		end
	end

	// cache credit count must track free queue slots
	a_no_overflow: assert property (@(posedge clk) disable iff (!arst_n)
		mreq_valid |-> (q_count < CNT_W'(MEM_CREDITS)));

endmodule

/* logic/mem_subsystem.sv */
`timescale 1ns/1ns

module mem_subsystem #(
	parameter int MEM_CREDITS = 4,   // queue depth and cache credits
	parameter int MEM_LATENCY = 3    // pop to completion
) (
	input  logic                         clk,
	input  logic                         arst_n,
	input  logic                         rd_en,
	input  logic                         wr_en,
	input  logic [cache_pkg::ADDR_W-1:0] addr,
	input  logic [cache_pkg::DATA_W-1:0] wr_data,
	output logic [cache_pkg::DATA_W-1:0] rd_data,
	output logic                         hit,
	output logic                         stall
);

	logic                         mreq_valid;
	mem_pkg::mem_op_e             mreq_op;
	logic [cache_pkg::ADDR_W-1:0] mreq_addr;
	logic [cache_pkg::DATA_W-1:0] mreq_data;
	logic                         credit_ret;
	logic                         mrsp_valid;
	logic [cache_pkg::DATA_W-1:0] mrsp_data;

	cache_unit #(
		.MEM_CREDITS (MEM_CREDITS)
	) u_cache (
		.clk        (clk),
		.arst_n     (arst_n),
		.rd_en      (rd_en),
		.wr_en      (wr_en),
		.addr       (addr),
		.wr_data    (wr_data),
		.credit_ret (credit_ret),
		.mrsp_valid (mrsp_valid),
		.mrsp_data  (mrsp_data),
		.rd_data    (rd_data),
		.hit        (hit),
		.stall      (stall),
		.mreq_valid (mreq_valid),
		.mreq_op    (mreq_op),
		.mreq_addr  (mreq_addr),
		.mreq_data  (mreq_data)
	);

	main_memory #(
		.MEM_CREDITS (MEM_CREDITS),
		.MEM_LATENCY (MEM_LATENCY)
	) u_mem (
		.clk        (clk),
		.arst_n     (arst_n),
		.mreq_valid (mreq_valid),
		.mreq_op    (mreq_op),
		.mreq_addr  (mreq_addr),
		.mreq_data  (mreq_data),
		.credit_ret (credit_ret),
		.mrsp_valid (mrsp_valid),
		.mrsp_data  (mrsp_data)
	);

endmodule

/* verif/tb_mem_subsystem.sv */
`timescale 1ns/1ns

module tb_mem_subsystem;

	localparam int STALL_LIMIT = 300;      // cycles a single request may stall

	logic        clk = 1'b0;
	logic        arst_n;
	logic        rd_en, wr_en;
	logic [15:0] addr, wr_data;
	logic [15:0] rd_data;
	logic        hit, stall;

	logic [31:0] lfsr_state = 32'd74373;
	logic [15:0] model_mem [mem_pkg::MEM_WORDS];    // expected backing store contents
	logic [4:0]  model_tag [cache_pkg::NUM_SETS];
	logic        model_valid [cache_pkg::NUM_SETS];
	logic [4:0]  tag_pool [4] = '{5'd0, 5'd9, 5'd22, 5'd31};
	logic [6:0]  set_pool [4] = '{7'd0, 7'd1, 7'd63, 7'd127};
	int          n_hits = 0;
	int          n_misses = 0;

	mem_subsystem #(
		.MEM_CREDITS (4),
		.MEM_LATENCY (3)
	) UUT (
		.clk     (clk),
		.arst_n  (arst_n),
		.rd_en   (rd_en),
		.wr_en   (wr_en),
		.addr    (addr),
		.wr_data (wr_data),
		.rd_data (rd_data),
		.hit     (hit),
		.stall   (stall)
	);

	always #4 clk = ~clk;                   // 8 ns period

	// x^32 + x^22 + x^2 + x + 1, shift left, feedback into bit 0
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		logic fb;
		fb = s[31] ^ s[21] ^ s[1] ^ s[0];
		return {s[30:0], fb};
	endfunction

	task automatic draw_bits(input int n, output logic [31:0] val);
		val = '0;
		for (int i = 0; i < n; i++) begin
			lfsr_state = lfsr_next(lfsr_state);
			val = {val[30:0], lfsr_state[0]};   // one step per bit
		end
	endtask

	task automatic check_value(input string name, input logic [15:0] got,
	                           input logic [15:0] exp);
		if (got !== exp) begin
			$display("ERROR at %0t ns: %s is %h, expected %h", $time, name, got, exp);
			$display("CHECKS FAILED");
			$fatal(1, "stopping at first mismatch");
		end
	endtask

	task automatic fail_run(input string what);
		$display("failure at %0t ns: %s", $time, what);
		$display("CHECKS FAILED");
		$fatal(1, "stopping run");
	endtask

	// tag | set | word | byte
	function automatic logic [15:0] build_addr(input logic [4:0] t, input logic [6:0] s,
	                                           input logic [2:0] w, input logic b);
		return {t, s, w, b};
	endfunction

	task automatic idle_cycles(input int n);
		rd_en = 1'b0;
		wr_en = 1'b0;
		repeat (n) @(negedge clk);
	endtask

	// called on a falling edge, returns on the falling edge after acceptance
	task automatic run_access(input logic is_wr, input logic [15:0] a, input logic [15:0] d,
	                          output logic got_hit);
		logic [4:0]  t;
		logic [6:0]  s;
		logic [14:0] w;
		logic        will_miss;
		int          waited;
		t = a[15:11];
		s = a[10:4];
		w = a[15:1];
		will_miss = !(model_valid[s] && model_tag[s] == t);
		rd_en   = !is_wr;
		wr_en   = is_wr;
		addr    = a;
		wr_data = d;
		#1;
		if (will_miss) check_value("stall", 16'(stall), 16'd1);   // miss stalls at once
		if (!will_miss && !is_wr) check_value("stall", 16'(stall), 16'd0);
		waited = 0;
		while (stall && waited < STALL_LIMIT) begin
			@(negedge clk);
			#1;
			waited++;
		end
		if (stall) fail_run("stall stayed high past the timeout");
		got_hit = hit;
		check_value("hit", 16'(hit), 16'(!will_miss));
		if (!is_wr) check_value("rd_data", rd_data, model_mem[w]);
		@(posedge clk);                     // request taken here
		if (will_miss) begin
			model_tag[s]   = t;
			model_valid[s] = 1'b1;
			n_misses++;
		end else begin
			n_hits++;
		end
		if (is_wr) model_mem[w] = d;            // write-through keeps memory current
		@(negedge clk);
	endtask

	initial begin
		logic [31:0] r_op, r_tag, r_set, r_word, r_byte, r_data, r_gap;
		logic [15:0] a, b;
		logic        h;

		arst_n  = 1'b0;
		rd_en   = 1'b0;
		wr_en   = 1'b0;
		addr    = '0;
		wr_data = '0;
		for (int w = 0; w < mem_pkg::MEM_WORDS; w++) begin
			model_mem[w] = 16'(w * 2) ^ 16'hC3A5;  // byte addr with bit 0 cleared
		end
		for (int s = 0; s < cache_pkg::NUM_SETS; s++) begin
			model_tag[s]   = '0;
			model_valid[s] = 1'b0;
		end

		repeat (16) @(posedge clk);
		@(negedge clk);
		arst_n = 1'b1;
		@(negedge clk);
		#1;
		check_value("stall", 16'(stall), 16'd0);
		check_value("hit", 16'(hit), 16'd0);
		@(negedge clk);

		// cold read must miss
		run_access(1'b0, build_addr(5'd0, 7'd0, 3'd0, 1'b0), 16'd0, h);
		check_value("hit", 16'(h), 16'd0);

		// random mix over a small tag and set pool
		n_hits   = 0;
		n_misses = 0;
		for (int k = 0; k < 400; k++) begin
			draw_bits(1, r_op);
			draw_bits(2, r_tag);
			draw_bits(2, r_set);
			draw_bits(3, r_word);
			draw_bits(1, r_byte);
			draw_bits(16, r_data);
			a = build_addr(tag_pool[r_tag[1:0]], set_pool[r_set[1:0]], r_word[2:0], r_byte[0]);
			run_access(r_op[0], a, r_data[15:0], h);
			draw_bits(2, r_gap);
			if (r_gap[1:0] == 2'd0) begin
				draw_bits(2, r_gap);
				idle_cycles(int'(r_gap[1:0]) + 1);
			end
		end
		$display("random mix: %0d hits, %0d misses", n_hits, n_misses);
		if (n_hits == 0 || n_misses == 0) begin
			fail_run("random mix did not produce both hits and misses");
		end

		// one set and two tags so every access after the first evicts
		a = build_addr(5'd3, 7'd5, 3'd2, 1'b0);
		b = build_addr(5'd12, 7'd5, 3'd6, 1'b0);
		run_access(1'b1, a, 16'hBEEF, h);
		for (int k = 0; k < 6; k++) begin
			run_access(1'b0, b, 16'd0, h);
			check_value("hit", 16'(h), 16'd0);
			run_access(1'b0, a, 16'd0, h);
			check_value("hit", 16'(h), 16'd0);
		end

		// write burst into one resident block runs the credits dry
		run_access(1'b0, build_addr(5'd17, 7'd9, 3'd0, 1'b0), 16'd0, h);
		for (int k = 0; k < 16; k++) begin
			draw_bits(16, r_data);
			run_access(1'b1, build_addr(5'd17, 7'd9, 3'(k), 1'b0), r_data[15:0], h);
		end
		for (int k = 0; k < 8; k++) begin
			run_access(1'b0, build_addr(5'd17, 7'd9, 3'(k), 1'b0), 16'd0, h);
		end
		// evict and refill so burst data must come back from memory
		run_access(1'b0, build_addr(5'd18, 7'd9, 3'd4, 1'b0), 16'd0, h);
		for (int k = 0; k < 8; k++) begin
			run_access(1'b0, build_addr(5'd17, 7'd9, 3'(k), 1'b0), 16'd0, h);
		end
		idle_cycles(4);

		$display("ALL CHECKS PASSED");
		$finish;
	end

endmodule

/* all.f */
logic/cache_pkg.sv
logic/mem_pkg.sv
logic/cache_meta_array.sv
logic/cache_data_array.sv
logic/cache_mem_ctrl.sv
logic/cache_unit.sv
logic/main_memory.sv
logic/mem_subsystem.sv
verif/tb_mem_subsystem.sv

/* run.sh */
#!/bin/sh
# build and run the cache testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f all.f --top-module tb_mem_subsystem -o tb_sim
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

out=$(./obj_dir/tb_sim)
status=$?
printf '%s\n' "$out"

if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if printf '%s\n' "$out" | grep -qx "ALL CHECKS PASSED"; then
	exit 0
fi
echo "pass message not found in simulation output"
exit 1
